//--- verilog/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN           = 32;
    localparam int ROB_ID_W       = 5;
    localparam int PHY_W          = 6;
    localparam int RAM_WORDS_LOG2 = 8;
    localparam int SEL_W          = XLEN / 8;  // One byte select per lane

    // Bit 3 marks a store, bits 1:0 give the access size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_t;

    function automatic logic is_store_op(input mem_op_t op);
        return op[3];
    endfunction

    // Byte enables for an aligned access of the op's size at a byte offset
    function automatic logic [SEL_W-1:0] mem_sel(input mem_op_t op, input logic [1:0] off);
        case (op[1:0])
            2'b00:   return SEL_W'(1) << off;
            2'b01:   return SEL_W'(3) << {off[1], 1'b0};
            default: return '1;
        endcase
    endfunction

endpackage

//--- verilog/load_queue.sv
`timescale 1ns/1ps
module load_queue
    import lsu_pkg::*;
#(
    parameter int LDQ_DEPTH = 4,
    parameter int STQ_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    input  logic                           ds_valid,
    input  mem_op_t                        ds_op,
    input  logic [ROB_ID_W-1:0]            ds_rob_id,
    input  logic [PHY_W-1:0]               ds_rd_phy,
    input  logic                           agu_valid,
    input  logic [ROB_ID_W-1:0]            agu_rob_id,
    input  logic [XLEN-1:0]                agu_addr,
    input  logic [$clog2(STQ_DEPTH):0]     stq_tail,
    input  logic                           stq_deq,
    input  logic                           ld_gnt,
    input  logic                           ld_resp,
    input  logic [XLEN-1:0]                rdata,
    output logic                           ldq_ready,
    output logic                           ld_req,
    output logic [XLEN-1:0]                ld_addr,
    output logic [SEL_W-1:0]               ld_sel,
    output logic                           cdb_valid,
    output logic [ROB_ID_W-1:0]            cdb_rob_id,
    output logic [PHY_W-1:0]               cdb_rd_phy,
    output logic [XLEN-1:0]                cdb_value,
    output logic [$clog2(LDQ_DEPTH+1)-1:0] ldq_count
);
    localparam int IDX_W = $clog2(LDQ_DEPTH);
    localparam int CNT_W = $clog2(STQ_DEPTH) + 1;
    localparam int LDC_W = $clog2(LDQ_DEPTH + 1);

    logic [LDQ_DEPTH-1:0] ent_valid;
    logic [LDQ_DEPTH-1:0] ent_addr_ok;
    logic [CNT_W-1:0]     ent_cnt    [LDQ_DEPTH];
    logic [ROB_ID_W-1:0]  ent_rob_id [LDQ_DEPTH];
    logic [PHY_W-1:0]     ent_rd_phy [LDQ_DEPTH];
    mem_op_t              ent_op     [LDQ_DEPTH];
    logic [XLEN-1:0]      ent_addr   [LDQ_DEPTH];

    logic [CNT_W-1:0]     stq_head;  // Mirrors the store queue head, advanced by stq_deq
    logic                 free_found;
    logic [IDX_W-1:0]     free_idx;
    logic                 issue_found;
    logic [IDX_W-1:0]     issue_idx;
    logic                 push;

    logic [ROB_ID_W-1:0]  stage_rob_id;
    logic [PHY_W-1:0]     stage_rd_phy;
    mem_op_t              stage_op;
    logic [1:0]           stage_off;
    logic                 stage_dropped;
    logic [7:0]           rd_byte;
    logic [15:0]          rd_half;

    // Lowest free slot and lowest ready load, scanned from the top down
    always_comb begin
        free_found  = 1'b0;
        free_idx    = '0;
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = LDQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (ent_valid[i] && ent_addr_ok[i] && ent_cnt[i] == '0) begin
                issue_found = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign ldq_ready = !flush && (is_store_op(ds_op) || free_found);
    assign push      = ds_valid && ldq_ready && !is_store_op(ds_op);
    assign ld_req    = issue_found && !flush;
    assign ld_addr   = {ent_addr[issue_idx][XLEN-1:2], 2'b00};
    assign ld_sel    = mem_sel(ent_op[issue_idx], ent_addr[issue_idx][1:0]);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ent_valid <= '0;
        end else begin
            if (ld_gnt) begin
                ent_valid[issue_idx] <= 1'b0;  // Slot reopens while the access is in flight
            end
            if (push) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LDQ_DEPTH; i++) begin
            if (stq_deq && ent_cnt[i] != '0) begin
                ent_cnt[i] <= ent_cnt[i] - 1'b1;
            end
            if (agu_valid && ent_valid[i] && ent_rob_id[i] == agu_rob_id) begin
                ent_addr_ok[i] <= 1'b1;
                ent_addr[i]    <= agu_addr;
            end
        end
        if (push) begin
            ent_addr_ok[free_idx] <= 1'b0;
            ent_cnt[free_idx]     <= stq_tail - stq_head - CNT_W'(stq_deq);
            ent_rob_id[free_idx]  <= ds_rob_id;
            ent_rd_phy[free_idx]  <= ds_rd_phy;
            ent_op[free_idx]      <= ds_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stq_head      <= '0;
            stage_dropped <= 1'b0;
        end else begin
            if (stq_deq) begin
                stq_head <= stq_head + 1'b1;
            end
            if (flush) begin
                stage_dropped <= 1'b1;
            end else if (ld_gnt) begin
                stage_dropped <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_gnt) begin
            stage_rob_id <= ent_rob_id[issue_idx];
            stage_rd_phy <= ent_rd_phy[issue_idx];
            stage_op     <= ent_op[issue_idx];
            stage_off    <= ent_addr[issue_idx][1:0];
        end
    end

    assign rd_byte = rdata[{stage_off, 3'b000} +: 8];
    assign rd_half = rdata[{stage_off[1], 4'b0000} +: 16];

    always_comb begin
        case (stage_op)
            MEM_LB:  cdb_value = {{(XLEN-8){rd_byte[7]}}, rd_byte};
            MEM_LBU: cdb_value = {{(XLEN-8){1'b0}}, rd_byte};
            MEM_LH:  cdb_value = {{(XLEN-16){rd_half[15]}}, rd_half};
            MEM_LHU: cdb_value = {{(XLEN-16){1'b0}}, rd_half};
            default: cdb_value = rdata;
        endcase
    end

    assign cdb_valid  = ld_resp && !stage_dropped && !flush;
    assign cdb_rob_id = stage_rob_id;
    assign cdb_rd_phy = stage_rd_phy;

    always_comb begin
        ldq_count = '0;
        for (int i = 0; i < LDQ_DEPTH; i++) begin
            ldq_count = ldq_count + LDC_W'(ent_valid[i]);
        end
    end

endmodule

//--- verilog/store_queue.sv
`timescale 1ns/1ps
module store_queue
    import lsu_pkg::*;
#(
    parameter int STQ_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       ds_valid,
    input  mem_op_t                    ds_op,
    input  logic [ROB_ID_W-1:0]        ds_rob_id,
    input  logic                       agu_valid,
    input  logic [ROB_ID_W-1:0]        agu_rob_id,
    input  logic [XLEN-1:0]            agu_addr,
    input  logic [XLEN-1:0]            agu_wdata,
    input  logic                       commit_store,
    input  logic                       st_gnt,
    input  logic                       st_resp,
    output logic                       stq_ready,
    output logic [$clog2(STQ_DEPTH):0] stq_tail,
    output logic                       stq_deq,
    output logic                       st_req,
    output logic [XLEN-1:0]            st_addr,
    output logic [SEL_W-1:0]           st_sel,
    output logic [XLEN-1:0]            st_wdata
);
    localparam int PTR_W = $clog2(STQ_DEPTH) + 1;  // Extra wrap bit tells full from empty
    localparam int IDX_W = PTR_W - 1;

    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [PTR_W-1:0]     cmt;
    logic                 st_busy;

    logic [STQ_DEPTH-1:0] ent_addr_ok;
    logic [ROB_ID_W-1:0]  ent_rob_id [STQ_DEPTH];
    mem_op_t              ent_op     [STQ_DEPTH];
    logic [XLEN-1:0]      ent_addr   [STQ_DEPTH];
    logic [XLEN-1:0]      ent_data   [STQ_DEPTH];

    logic                 push;
    logic                 commit_ok;
    logic [IDX_W-1:0]     head_idx;
    logic [1:0]           off;

    assign head_idx  = head[IDX_W-1:0];
    assign stq_ready = !flush && (!is_store_op(ds_op) || (tail - head) != PTR_W'(STQ_DEPTH));
    assign push      = ds_valid && stq_ready && is_store_op(ds_op);
    assign commit_ok = commit_store && cmt != tail;
    assign stq_tail  = tail;
    assign stq_deq   = st_resp;

    // Only a committed head with its address goes to memory
    assign st_req  = cmt != head && ent_addr_ok[head_idx] && !st_busy;
    assign off     = ent_addr[head_idx][1:0];
    assign st_addr = {ent_addr[head_idx][XLEN-1:2], 2'b00};
    assign st_sel  = mem_sel(ent_op[head_idx], off);

    always_comb begin
        case (ent_op[head_idx])
            MEM_SB:  st_wdata = XLEN'(ent_data[head_idx][7:0]) << {off, 3'b000};
            MEM_SH:  st_wdata = XLEN'(ent_data[head_idx][15:0]) << {off[1], 4'b0000};
            default: st_wdata = ent_data[head_idx];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            cmt     <= '0;
            st_busy <= 1'b0;
        end else begin
            if (st_resp) begin
                head <= head + 1'b1;
            end
            if (commit_ok) begin
                cmt <= cmt + 1'b1;
            end
            if (flush) begin
                tail <= cmt + PTR_W'(commit_ok);  // Uncommitted stores are dropped
            end else if (push) begin
                tail <= tail + 1'b1;
            end
            if (st_gnt) begin
                st_busy <= 1'b1;
            end else if (st_resp) begin
                st_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < STQ_DEPTH; i++) begin
            if (agu_valid && ent_rob_id[i] == agu_rob_id) begin
                ent_addr_ok[i] <= 1'b1;
                ent_addr[i]    <= agu_addr;
                ent_data[i]    <= agu_wdata;
            end
        end
        if (push) begin
            ent_addr_ok[tail[IDX_W-1:0]] <= 1'b0;
            ent_rob_id[tail[IDX_W-1:0]]  <= ds_rob_id;
            ent_op[tail[IDX_W-1:0]]      <= ds_op;
        end
    end

endmodule

//--- verilog/mem_bus_port.sv
`timescale 1ns/1ps
module mem_bus_port
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ld_req,
    input  logic [XLEN-1:0]  ld_addr,
    input  logic [SEL_W-1:0] ld_sel,
    input  logic             st_req,
    input  logic [XLEN-1:0]  st_addr,
    input  logic [SEL_W-1:0] st_sel,
    input  logic [XLEN-1:0]  st_wdata,
    input  logic             ack,
    input  logic [XLEN-1:0]  dat_r,
    output logic             ld_gnt,
    output logic             st_gnt,
    output logic             ld_resp,
    output logic             st_resp,
    output logic [XLEN-1:0]  rdata,
    output logic             cyc,
    output logic             stb,
    output logic             we,
    output logic [XLEN-1:0]  adr,
    output logic [XLEN-1:0]  dat_w,
    output logic [SEL_W-1:0] sel
);
    logic busy;

    assign st_gnt = !busy && st_req;  // Stores win over loads
    assign ld_gnt = !busy && ld_req && !st_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (!busy) begin
            busy <= st_gnt || ld_gnt;
        end else if (ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (st_gnt || ld_gnt) begin
            we    <= st_gnt;
            adr   <= st_gnt ? st_addr : ld_addr;
            sel   <= st_gnt ? st_sel : ld_sel;
            dat_w <= st_wdata;
        end
    end

    assign cyc     = busy;
    assign stb     = busy;
    assign ld_resp = busy && ack && !we;
    assign st_resp = busy && ack && we;
    assign rdata   = dat_r;

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps
module data_ram
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [XLEN-1:0]  adr,
    input  logic [XLEN-1:0]  dat_w,
    input  logic [SEL_W-1:0] sel,
    output logic             ack,
    output logic [XLEN-1:0]  dat_r
);
    logic [XLEN-1:0]           mem [2**RAM_WORDS_LOG2];
    logic [RAM_WORDS_LOG2-1:0] word;
    logic                      access;

    assign word   = adr[RAM_WORDS_LOG2+1:2];
    assign access = cyc && stb && !ack;  // The ack cycle is not a new strobe

    initial begin
        for (int i = 0; i < 2**RAM_WORDS_LOG2; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= mem[word];
            if (we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) begin
                        mem[word][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- verilog/lsu_top.sv
`timescale 1ns/1ps
module lsu_top
    import lsu_pkg::*;
#(
    parameter int LDQ_DEPTH = 4,
    parameter int STQ_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    input  logic                           ds_valid,
    output logic                           ds_ready,
    input  mem_op_t                        ds_op,
    input  logic [ROB_ID_W-1:0]            ds_rob_id,
    input  logic [PHY_W-1:0]               ds_rd_phy,
    input  logic                           agu_valid,
    input  logic [ROB_ID_W-1:0]            agu_rob_id,
    input  logic [XLEN-1:0]                agu_addr,
    input  logic [XLEN-1:0]                agu_wdata,
    input  logic                           commit_store,
    output logic                           cdb_valid,
    output logic [ROB_ID_W-1:0]            cdb_rob_id,
    output logic [PHY_W-1:0]               cdb_rd_phy,
    output logic [XLEN-1:0]                cdb_value,
    output logic [$clog2(LDQ_DEPTH+1)-1:0] ldq_count
);
    logic                       ldq_ready;
    logic                       stq_ready;
    logic [$clog2(STQ_DEPTH):0] stq_tail;
    logic                       stq_deq;
    logic                       ld_req;
    logic                       ld_gnt;
    logic                       ld_resp;
    logic [XLEN-1:0]            ld_addr;
    logic [SEL_W-1:0]           ld_sel;
    logic [XLEN-1:0]            rdata;
    logic                       st_req;
    logic                       st_gnt;
    logic                       st_resp;
    logic [XLEN-1:0]            st_addr;
    logic [SEL_W-1:0]           st_sel;
    logic [XLEN-1:0]            st_wdata;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic                       ack;
    logic [XLEN-1:0]            adr;
    logic [XLEN-1:0]            dat_w;
    logic [XLEN-1:0]            dat_r;
    logic [SEL_W-1:0]           sel;

    assign ds_ready = ldq_ready && stq_ready;  // Each queue only blocks ops of its own kind

    load_queue #(
        .LDQ_DEPTH (LDQ_DEPTH),
        .STQ_DEPTH (STQ_DEPTH)
    ) load_queue_inst (.*);

    store_queue #(
        .STQ_DEPTH (STQ_DEPTH)
    ) store_queue_inst (.*);

    mem_bus_port mem_bus_port_inst (.*);

    data_ram data_ram_inst (.*);

endmodule

//--- test/lsu_tb.sv
`timescale 1ns/1ps
module lsu_tb
    import lsu_pkg::*;
();
    localparam int LDQ_DEPTH = 4;
    localparam int STQ_DEPTH = 4;
    localparam int LDC_W     = $clog2(LDQ_DEPTH + 1);
    localparam int NUM_OPS   = 160;
    localparam int FLUSH_AT  = 90;  // Dispatch count at which the flush fires
    localparam int HOLD_AT   = 30;  // Dispatch count at which the address unit stalls
    localparam int WATCHDOG  = 200 * NUM_OPS + 16;
    localparam int SEED      = 38629;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                ds_valid;
    logic                ds_ready;
    mem_op_t             ds_op;
    logic [ROB_ID_W-1:0] ds_rob_id;
    logic [PHY_W-1:0]    ds_rd_phy;
    logic                agu_valid;
    logic [ROB_ID_W-1:0] agu_rob_id;
    logic [XLEN-1:0]     agu_addr;
    logic [XLEN-1:0]     agu_wdata;
    logic                commit_store;
    logic                cdb_valid;
    logic [ROB_ID_W-1:0] cdb_rob_id;
    logic [PHY_W-1:0]    cdb_rd_phy;
    logic [XLEN-1:0]     cdb_value;
    logic [LDC_W-1:0]    ldq_count;

    mem_op_t             op_list [8] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
                                         MEM_LHU, MEM_SB, MEM_SH, MEM_SW};
    logic [31:0]         spec_mem [8];  // Memory as program order sees it
    logic [31:0]         arch_mem [8];  // Memory with committed stores only
    bit                  ld_pend [32];
    logic [31:0]         ld_exp [32];
    logic [PHY_W-1:0]    ld_phy [32];
    int                  ld_seq [32];
    int                  st_seq_q [$];
    mem_op_t             st_op_q [$];
    logic [31:0]         st_addr_q [$];
    logic [31:0]         st_data_q [$];
    logic [ROB_ID_W-1:0] agu_rob_q [$];
    logic [31:0]         agu_addr_q [$];
    logic [31:0]         agu_data_q [$];
    int                  agu_due_q [$];
    int                  agu_seq_q [$];
    mem_op_t             cur_op;
    logic [31:0]         cur_addr;
    logic [31:0]         cur_data;
    int                  cycle;
    int                  n_disp;
    int                  pend_loads;
    int                  cmt_seq = -1;
    int                  hold_left;
    int                  n_checked;
    int                  mism_errs;
    int                  other_errs;
    bit                  flushed;
    bit                  held;
    bit                  saw_block;
    bit                  all_done;

    lsu_top #(
        .LDQ_DEPTH (LDQ_DEPTH),
        .STQ_DEPTH (STQ_DEPTH)
    ) lsu_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A load offered to a full load queue must be held off
    assert property (@(posedge clk) disable iff (!rst_n)
                     ds_valid && !ds_op[3] && ldq_count == LDC_W'(LDQ_DEPTH) |-> !ds_ready)
        else begin
            mism_errs++;
            $display("Mismatch at %0t on ds_ready: expected 0, actual 1", $time);
        end

    // Merges a store into a memory word by its size and byte offset
    function automatic logic [31:0] store_merge(input logic [31:0] old, input mem_op_t op,
                                                input logic [1:0] off, input logic [31:0] data);
        logic [31:0] w;
        w = old;
        case (op)
            MEM_SB:  w[8*off +: 8] = data[7:0];
            MEM_SH:  w[16*off[1] +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] w, input mem_op_t op,
                                               input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = w[16*off[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic bit older_load_pending(input int seq);
        for (int i = 0; i < 32; i++) begin
            if (ld_pend[i] && ld_seq[i] < seq) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Loads still waiting for an address must sit in the queue and no written back load may
    task automatic check_queue_count();
        int lo;
        int hi;
        lo = 0;
        for (int i = 0; i < agu_rob_q.size(); i++) begin
            if (ld_pend[agu_rob_q[i]] && ld_seq[agu_rob_q[i]] == agu_seq_q[i]) begin
                lo++;
            end
        end
        hi = pend_loads < LDQ_DEPTH ? pend_loads : LDQ_DEPTH;
        assert (ldq_count >= lo && ldq_count <= hi) else begin
            other_errs++;
            $display("ldq_count is %0d at %0t, outside the range %0d to %0d of queued loads",
                     ldq_count, $time, lo, hi);
        end
    endtask

    task automatic check_result();
        logic [ROB_ID_W-1:0] r;
        r = cdb_rob_id;
        assert (ld_pend[r]) else begin
            other_errs++;
            $display("CDB result at %0t for rob_id %0d, which has no pending load", $time, r);
        end
        if (ld_pend[r]) begin
            assert (cdb_rd_phy == ld_phy[r]) else begin
                mism_errs++;
                $display("Mismatch at %0t on cdb_rd_phy: expected %0d, actual %0d",
                         $time, ld_phy[r], cdb_rd_phy);
            end
            assert (cdb_value == ld_exp[r]) else begin
                mism_errs++;
                $display("Mismatch at %0t on cdb_value (rob_id %0d): expected %h, actual %h",
                         $time, r, ld_exp[r], cdb_value);
            end
            ld_pend[r] = 1'b0;
            pend_loads--;
            n_checked++;
        end
    endtask

    task automatic accept_op();
        logic [2:0] w;
        w = cur_addr[4:2];
        if (cur_op[3]) begin
            spec_mem[w] = store_merge(spec_mem[w], cur_op, cur_addr[1:0], cur_data);
            st_seq_q.push_back(n_disp);
            st_op_q.push_back(cur_op);
            st_addr_q.push_back(cur_addr);
            st_data_q.push_back(cur_data);
        end else begin
            ld_pend[ds_rob_id] = 1'b1;
            ld_exp[ds_rob_id]  = load_value(spec_mem[w], cur_op, cur_addr[1:0]);
            ld_phy[ds_rob_id]  = ds_rd_phy;
            ld_seq[ds_rob_id]  = n_disp;
            pend_loads++;
        end
        agu_rob_q.push_back(ds_rob_id);
        agu_addr_q.push_back(cur_addr);
        agu_data_q.push_back(cur_data);
        agu_due_q.push_back(cycle + 1 + $urandom_range(5, 0));
        agu_seq_q.push_back(n_disp);
        n_disp++;
    endtask

    task automatic present_op();
        int k;
        k        = $urandom_range(7, 0);
        cur_op   = op_list[k];
        cur_addr = $urandom_range(31, 0) & ~((32'd1 << cur_op[1:0]) - 32'd1);  // Aligned
        cur_data = $urandom;
        ds_valid  <= 1'b1;
        ds_op     <= cur_op;
        ds_rob_id <= ROB_ID_W'(n_disp);
        ds_rd_phy <= PHY_W'($urandom);
    endtask

    task automatic commit_oldest_store();
        logic [2:0] w;
        w = st_addr_q[0][4:2];
        arch_mem[w] = store_merge(arch_mem[w], st_op_q[0], st_addr_q[0][1:0], st_data_q[0]);
        cmt_seq = st_seq_q.pop_front();
        void'(st_op_q.pop_front());
        void'(st_addr_q.pop_front());
        void'(st_data_q.pop_front());
        commit_store <= 1'b1;
    endtask

    task automatic send_address(input int k);
        agu_valid  <= 1'b1;
        agu_rob_id <= agu_rob_q[k];
        agu_addr   <= agu_addr_q[k];
        agu_wdata  <= agu_data_q[k];
        agu_rob_q.delete(k);
        agu_addr_q.delete(k);
        agu_data_q.delete(k);
        agu_due_q.delete(k);
        agu_seq_q.delete(k);
    endtask

    // Committed stores keep their address unit entries, everything younger is gone
    task automatic forget_speculative();
        for (int i = 0; i < 32; i++) begin
            ld_pend[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            spec_mem[i] = arch_mem[i];
        end
        pend_loads = 0;
        st_seq_q.delete();
        st_op_q.delete();
        st_addr_q.delete();
        st_data_q.delete();
        for (int i = agu_seq_q.size() - 1; i >= 0; i--) begin
            if (agu_seq_q[i] > cmt_seq) begin
                agu_rob_q.delete(i);
                agu_addr_q.delete(i);
                agu_data_q.delete(i);
                agu_due_q.delete(i);
                agu_seq_q.delete(i);
            end
        end
    endtask

    task automatic step_cycle();
        int k;
        bit flush_now;
        cycle++;
        flush_now = 1'b0;
        if (!flush) begin
            check_queue_count();
        end
        if (cdb_valid) begin
            check_result();
        end
        if (ds_valid && ds_ready) begin
            accept_op();
        end
        if (hold_left > 0 && ds_valid && !ds_ready) begin
            saw_block = 1'b1;
        end
        if (!ds_valid || ds_ready) begin
            if (n_disp < NUM_OPS) begin
                present_op();
            end else begin
                ds_valid <= 1'b0;
            end
        end
        if (n_disp == FLUSH_AT && !flushed) begin
            flushed   = 1'b1;
            flush_now = 1'b1;
            forget_speculative();
        end
        flush        <= flush_now;
        commit_store <= 1'b0;
        if (!flush_now && st_seq_q.size() > 0 && !older_load_pending(st_seq_q[0])) begin
            commit_oldest_store();
        end
        if (n_disp >= HOLD_AT && !held) begin
            held      = 1'b1;
            hold_left = 40;  // Address unit goes quiet so both queues fill up
        end
        agu_valid <= 1'b0;
        if (hold_left > 0) begin
            hold_left--;
        end else if (!flush_now && agu_rob_q.size() > 0) begin
            k = $urandom_range(agu_rob_q.size() - 1, 0);
            if (agu_due_q[k] <= cycle) begin
                send_address(k);
            end
        end
        all_done = n_disp == NUM_OPS && pend_loads == 0 && st_seq_q.size() == 0
                   && agu_rob_q.size() == 0;
    endtask

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < 8; i++) begin
            spec_mem[i] = '0;
            arch_mem[i] = '0;
        end
        rst_n        <= 1'b0;
        flush        <= 1'b0;
        ds_valid     <= 1'b0;
        ds_op        <= MEM_LB;
        ds_rob_id    <= '0;
        ds_rd_phy    <= '0;
        agu_valid    <= 1'b0;
        agu_rob_id   <= '0;
        agu_addr     <= '0;
        agu_wdata    <= '0;
        commit_store <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!cdb_valid) else begin
            mism_errs++;
            $display("Mismatch at %0t on cdb_valid: expected 0, actual %b", $time, cdb_valid);
        end
        assert (ds_ready) else begin
            mism_errs++;
            $display("Mismatch at %0t on ds_ready: expected 1, actual %b", $time, ds_ready);
        end
        while (!all_done) begin
            @(posedge clk);
            step_cycle();
        end
        assert (saw_block) else begin
            other_errs++;
            $display("ds_ready never went low while the address unit was held back");
        end
        $display("Checked %0d loads: %0d mismatches, %0d other errors",
                 n_checked, mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
verilog/lsu_pkg.sv
verilog/load_queue.sv
verilog/store_queue.sv
verilog/mem_bus_port.sv
verilog/data_ram.sv
verilog/lsu_top.sv
test/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Builds the LSU testbench with Verilator, runs it and checks run.log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lsu_tb -f flist.f -o lsu_sim
./obj_dir/lsu_sim > run.log 2>&1
cat run.log
grep -qx "TEST PASS" run.log
